/* bench/soc_top_tb.sv */
`timescale 1ns/1ps

module soc_top_tb;

   import soc_pkg::*;

   localparam int NUM_OPS   = 17;
   localparam int ACK_LIMIT = 16;
   localparam int RST_LIMIT = 400;

   typedef struct packed {
      logic             we;
      logic [WB_AW-1:0] adr;
      logic [WB_DW-1:0] dat;
      logic [WB_SW-1:0] sel;
      logic [WB_DW-1:0] rd_exp;
   } bus_op_t;

   logic                wb_clk;
   logic                i_rst_n;
   logic [WB_AW-1:0]    i_wb_adr;
   logic [WB_DW-1:0]    i_wb_dat;
   logic [WB_SW-1:0]    i_wb_sel;
   logic                i_wb_we;
   logic                i_wb_cyc;
   logic [WB_DW-1:0]    o_wb_rdt;
   logic                o_wb_ack;
   logic                o_core_rst;
   logic                o_led;
   logic                o_tx;
   logic [GPIO_W-1:0]   o_test;

   bus_op_t          ops [NUM_OPS];
   logic [WB_DW-1:0] rdt;
   logic [WB_DW-1:0] rand_a;
   logic [WB_DW-1:0] rand_b;
   logic [7:0]       rx_byte;
   int               n_hi;
   int               n_lo;

   soc_top soc_top_i (
      .wb_clk     (wb_clk),
      .i_rst_n    (i_rst_n),
      .i_wb_adr   (i_wb_adr),
      .i_wb_dat   (i_wb_dat),
      .i_wb_sel   (i_wb_sel),
      .i_wb_we    (i_wb_we),
      .i_wb_cyc   (i_wb_cyc),
      .o_wb_rdt   (o_wb_rdt),
      .o_wb_ack   (o_wb_ack),
      .o_core_rst (o_core_rst),
      .o_led      (o_led),
      .o_tx       (o_tx),
      .o_test     (o_test)
   );

   initial begin
      wb_clk = 1'b0;
      forever #2 wb_clk = ~wb_clk;
   end

   // ==================================================
   // reporting and compare tasks
   // ==================================================

   task automatic abort_run(input string line);
      $display("%s", line);
      $display("tests failed");
      $fatal(1);
   endtask

   task automatic check_word(input string what, input logic [WB_DW-1:0] got,
                             input logic [WB_DW-1:0] expected);
      if (got !== expected)
         abort_run($sformatf("Fail at %0t ns: %s expected %h got %h",
                             $time, what, expected, got));
   endtask

   task automatic check_pins(input string what, input logic [GPIO_W-1:0] got,
                             input logic [GPIO_W-1:0] expected);
      if (got !== expected)
         abort_run($sformatf("Fail at %0t ns: %s expected %h got %h",
                             $time, what, expected, got));
   endtask

   task automatic check_bit(input string what, input logic got, input logic expected);
      if (got !== expected)
         abort_run($sformatf("Fail at %0t ns: %s expected %b got %b",
                             $time, what, expected, got));
   endtask

   task automatic check_byte(input string what, input logic [7:0] got,
                             input logic [7:0] expected);
      if (got !== expected)
         abort_run($sformatf("Fail at %0t ns: %s expected %h got %h",
                             $time, what, expected, got));
   endtask

   task automatic check_count(input string what, input int got, input int expected);
      if (got != expected)
         abort_run($sformatf("Fail at %0t ns: %s expected %0d cycles got %0d",
                             $time, what, expected, got));
   endtask

   // ==================================================
   // bus master, UART receiver and reset watcher
   // ==================================================

   function automatic logic [WB_AW-1:0] reg_addr(input logic [1:0] idx);
      return {{(WB_AW-4){1'b0}}, idx, 2'b00};
   endfunction

   function automatic bus_op_t make_op(input logic we, input logic [WB_AW-1:0] adr,
                                       input logic [WB_DW-1:0] dat,
                                       input logic [WB_SW-1:0] sel,
                                       input logic [WB_DW-1:0] rd_exp);
      bus_op_t op;
      op.we     = we;
      op.adr    = adr;
      op.dat    = dat;
      op.sel    = sel;
      op.rd_exp = rd_exp;
      return op;
   endfunction

   // one access; ack must come one cycle after cyc and drop right after.
   task automatic bus_access(input bus_op_t op, output logic [WB_DW-1:0] data);
      int cycles;
      @(negedge wb_clk);
      i_wb_adr = op.adr;
      i_wb_dat = op.dat;
      i_wb_sel = op.sel;
      i_wb_we  = op.we;
      i_wb_cyc = 1'b1;
      cycles   = 0;
      do begin
         @(negedge wb_clk);
         cycles++;
         if (cycles > ACK_LIMIT)
            abort_run($sformatf("no bus acknowledge within %0d cycles at %0t ns",
                                ACK_LIMIT, $time));
      end while (o_wb_ack !== 1'b1);
      check_count("ack latency", cycles, 1);
      data     = o_wb_rdt;
      i_wb_cyc = 1'b0;
      i_wb_we  = 1'b0;
      @(negedge wb_clk);
      check_bit("ack after access", o_wb_ack, 1'b0);
   endtask

   // samples each bit in its middle, counted from the start bit edge.
   task automatic receive_byte(output logic [7:0] data);
      int waited;
      waited = 0;
      do begin
         @(negedge wb_clk);
         waited++;
         if (waited > 4 * CLKS_PER_BIT)
            abort_run($sformatf("no UART start bit seen by %0t ns", $time));
      end while (o_tx !== 1'b0);
      repeat (CLKS_PER_BIT / 2) @(negedge wb_clk);
      check_bit("start bit", o_tx, 1'b0);
      for (int i = 0; i < 8; i++) begin
         repeat (CLKS_PER_BIT) @(negedge wb_clk);
         data[i] = o_tx;
      end
      repeat (CLKS_PER_BIT) @(negedge wb_clk);
      check_bit("stop bit", o_tx, 1'b1);
   endtask

   task automatic wait_core_rst(input logic level, input int limit, output int cycles);
      cycles = 0;
      do begin
         @(negedge wb_clk);
         cycles++;
         if (cycles > limit)
            abort_run($sformatf("core reset did not reach %b within %0d cycles",
                                level, limit));
      end while (o_core_rst !== level);
   endtask

   // ==================================================
   // stimulus
   // ==================================================

   initial begin
      i_rst_n  = 1'b0;
      i_wb_adr = '0;
      i_wb_dat = '0;
      i_wb_sel = '0;
      i_wb_we  = 1'b0;
      i_wb_cyc = 1'b0;
      void'($urandom(44));
      rand_a = $urandom();
      rand_b = $urandom();

      // each GPIO write has to differ from the value the pins held before it.
      if (rand_a[7:0] == 8'h00)
         rand_a[7:0] = 8'h81;
      if (rand_b[7:0] == rand_a[7:0])
         rand_b[7:0] = ~rand_a[7:0];

      // register table; the masked write must leave rand_a in place.
      ops[0]  = make_op(0, reg_addr(REG_GPIO), '0, 4'hf, '0);
      ops[1]  = make_op(0, reg_addr(REG_LED), '0, 4'hf, '0);
      ops[2]  = make_op(0, reg_addr(REG_UART), '0, 4'hf, '0);
      ops[3]  = make_op(0, reg_addr(REG_RSTP), '0, 4'hf, '0);
      ops[4]  = make_op(1, reg_addr(REG_GPIO), rand_a, 4'h1, '0);
      ops[5]  = make_op(0, reg_addr(REG_GPIO), '0, 4'hf, {24'h0, rand_a[7:0]});
      ops[6]  = make_op(1, reg_addr(REG_LED), 32'h1, 4'hf, '0);
      ops[7]  = make_op(0, reg_addr(REG_LED), '0, 4'hf, 32'h1);
      ops[8]  = make_op(1, reg_addr(REG_GPIO), ~rand_a, 4'h0, '0);
      ops[9]  = make_op(0, reg_addr(REG_GPIO), '0, 4'hf, {24'h0, rand_a[7:0]});
      ops[10] = make_op(1, reg_addr(REG_GPIO) | 32'habcd_0100, rand_b, 4'h1, '0);
      ops[11] = make_op(0, reg_addr(REG_GPIO), '0, 4'hf, {24'h0, rand_b[7:0]});
      ops[12] = make_op(0, reg_addr(REG_LED) | 32'h8000_0100, '0, 4'hf, 32'h1);
      ops[13] = make_op(1, reg_addr(REG_RSTP), 32'h123, 4'h3, '0);
      ops[14] = make_op(0, reg_addr(REG_RSTP), '0, 4'hf, 32'h123);
      ops[15] = make_op(1, reg_addr(REG_RSTP), 32'h0, 4'h3, '0);
      ops[16] = make_op(0, reg_addr(REG_RSTP), '0, 4'hf, 32'h0);

      repeat (10) @(negedge wb_clk);
      i_rst_n = 1'b1;
      wait_core_rst(1'b0, 20, n_hi);
      check_count("core reset stretch", n_hi, RST_STRETCH);
      check_bit("idle tx line", o_tx, 1'b1);
      check_bit("led after reset", o_led, 1'b0);
      check_pins("test pins after reset", o_test, '0);
      check_bit("ack after reset", o_wb_ack, 1'b0);

      for (int i = 0; i < NUM_OPS; i++) begin
         bus_access(ops[i], rdt);
         if (!ops[i].we)
            check_word($sformatf("read data of entry %0d", i), rdt, ops[i].rd_exp);
      end
      check_pins("test pins", o_test, rand_b[GPIO_W-1:0]);
      check_bit("led", o_led, 1'b1);

      // the second byte arrives while busy and has to be dropped.
      fork
         begin
            bus_access(make_op(1, reg_addr(REG_UART), 32'h5a, 4'h1, '0), rdt);
            bus_access(make_op(0, reg_addr(REG_UART), '0, 4'hf, '0), rdt);
            check_word("busy during frame", rdt, 32'h1);
            bus_access(make_op(1, reg_addr(REG_UART), 32'hc3, 4'h1, '0), rdt);
         end
         receive_byte(rx_byte);
      join
      check_byte("received byte", rx_byte, 8'h5a);
      repeat (CLKS_PER_BIT) @(negedge wb_clk);
      bus_access(make_op(0, reg_addr(REG_UART), '0, 4'hf, '0), rdt);
      check_word("busy after frame", rdt, 32'h0);
      repeat (12 * CLKS_PER_BIT) begin
         @(negedge wb_clk);
         check_bit("idle tx after dropped write", o_tx, 1'b1);
      end

      // periodic core reset with an interval of 40 cycles.
      bus_access(make_op(1, reg_addr(REG_RSTP), 32'd40, 4'h3, '0), rdt);
      wait_core_rst(1'b1, RST_LIMIT, n_lo);
      repeat (3) begin
         wait_core_rst(1'b0, 20, n_hi);
         check_count("core reset pulse", n_hi, RST_STRETCH);
         wait_core_rst(1'b1, RST_LIMIT, n_lo);
         check_count("core reset interval", n_hi + n_lo, 40);
      end
      bus_access(make_op(1, reg_addr(REG_RSTP), 32'd0, 4'h3, '0), rdt);
      wait_core_rst(1'b0, 20, n_hi);
      repeat (200) begin
         @(negedge wb_clk);
         check_bit("core reset with interval 0", o_core_rst, 1'b0);
      end

      $display("all tests passed");
      $finish;
   end

endmodule

/* verilog/reset_gen.sv */
`timescale 1ns/1ps

module reset_gen (
   input  logic                         wb_clk,
   input  logic                         i_rst_n,
   input  logic [soc_pkg::RSTCNT_W-1:0] i_period,
   input  logic                         i_period_wr,
   output logic                         o_core_rst
);

   import soc_pkg::*;

   // the low bit of the stretcher drives the core reset.
   logic [RST_STRETCH-1:0] stretch;

   // free running interval counter.
   logic [RSTCNT_W-1:0] cnt;
   logic                period_on;
   logic                wrap;

   assign period_on = (i_period != '0);

   // the counter wraps after interval minus one, which restarts the stretcher.
   // a new interval written this cycle suppresses the event.
   assign wrap = period_on && !i_period_wr && (cnt == i_period - RSTCNT_W'(1));

   // ==================================================
   // interval counter
   // ==================================================

   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         cnt <= '0;
      end else if (i_period_wr || !period_on || wrap) begin
         // a write, a zero interval or a wrap all start over from zero.
         cnt <= '0;
      end else begin
         cnt <= cnt + RSTCNT_W'(1);
      end
   end

   // ==================================================
   // reset stretcher
   // ==================================================

   // external reset and every interval event load ones.
   // zeros then shift in from the top, so the pulse lasts RST_STRETCH cycles.
   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         stretch <= '1;
      end else if (wrap) begin
         stretch <= '1;
      end else begin
         stretch <= {1'b0, stretch[RST_STRETCH-1:1]};
      end
   end

   // the core reset leaves the chip and is not used by any block here.
   assign o_core_rst = stretch[0];

endmodule

/* verilog/soc_pkg.sv */
package soc_pkg;

   // ==================================================
   // data bus geometry
   // ==================================================

   // the data bus is 32 bits wide with one select per byte.
   localparam int WB_AW = 32;
   localparam int WB_DW = 32;
   localparam int WB_SW = 4;

   // number of test pins brought out to the board header.
   localparam int GPIO_W = 8;

   // ==================================================
   // reset generator
   // ==================================================

   // width of the reset interval register and of its counter.
   localparam int RSTCNT_W = 12;

   // length of one core reset pulse in wb_clk cycles.
   localparam int RST_STRETCH = 5;

   // ==================================================
   // serial transmitter
   // ==================================================

   // wb_clk cycles per UART bit and the width of the baud counter.
   localparam int CLKS_PER_BIT = 8;
   localparam int BAUD_W = $clog2(CLKS_PER_BIT);

   // register indices, taken from address bits 3 to 2.
   localparam logic [1:0] REG_GPIO = 2'd0;
   localparam logic [1:0] REG_LED  = 2'd1;
   localparam logic [1:0] REG_UART = 2'd2;
   localparam logic [1:0] REG_RSTP = 2'd3;

endpackage

/* verilog/soc_top.sv */
`timescale 1ns/1ps

module soc_top (
   input  logic                       wb_clk,
   input  logic                       i_rst_n,

   // data bus, mastered by the core outside this block.
   input  logic [soc_pkg::WB_AW-1:0]  i_wb_adr,
   input  logic [soc_pkg::WB_DW-1:0]  i_wb_dat,
   input  logic [soc_pkg::WB_SW-1:0]  i_wb_sel,
   input  logic                       i_wb_we,
   input  logic                       i_wb_cyc,
   output logic [soc_pkg::WB_DW-1:0]  o_wb_rdt,
   output logic                       o_wb_ack,

   output logic                       o_core_rst,
   output logic                       o_led,
   output logic                       o_tx,
   output logic [soc_pkg::GPIO_W-1:0] o_test
);

   import soc_pkg::*;

   // register block to transmitter.
   logic       tx_stb;
   logic [7:0] tx_data;
   logic       tx_busy;

   // register block to reset generator.
   logic [RSTCNT_W-1:0] period;
   logic                period_wr;

   // ==================================================
   // blocks
   // ==================================================

   wb_regs wb_regs_i (
      .wb_clk      (wb_clk),
      .i_rst_n     (i_rst_n),
      .i_wb_adr    (i_wb_adr),
      .i_wb_dat    (i_wb_dat),
      .i_wb_sel    (i_wb_sel),
      .i_wb_we     (i_wb_we),
      .i_wb_cyc    (i_wb_cyc),
      .o_wb_rdt    (o_wb_rdt),
      .o_wb_ack    (o_wb_ack),
      .o_test      (o_test),
      .o_led       (o_led),
      .o_tx_stb    (tx_stb),
      .o_tx_data   (tx_data),
      .i_tx_busy   (tx_busy),
      .o_period    (period),
      .o_period_wr (period_wr)
   );

   uart_tx uart_tx_i (
      .wb_clk    (wb_clk),
      .i_rst_n   (i_rst_n),
      .i_tx_stb  (tx_stb),
      .i_tx_data (tx_data),
      .o_tx      (o_tx),
      .o_busy    (tx_busy)
   );

   reset_gen reset_gen_i (
      .wb_clk      (wb_clk),
      .i_rst_n     (i_rst_n),
      .i_period    (period),
      .i_period_wr (period_wr),
      .o_core_rst  (o_core_rst)
   );

endmodule

/* verilog/uart_tx.sv */
`timescale 1ns/1ps

module uart_tx (
   input  logic       wb_clk,
   input  logic       i_rst_n,
   input  logic       i_tx_stb,
   input  logic [7:0] i_tx_data,
   output logic       o_tx,
   output logic       o_busy
);

   import soc_pkg::*;

   // frame layout from bit 0 upwards is the start bit, the data LSB first and the stop bit.
   logic [9:0]        shreg;
   logic [BAUD_W-1:0] baud_cnt;
   logic [3:0]        bit_cnt;
   logic              bit_end;

   assign bit_end = (baud_cnt == BAUD_W'(CLKS_PER_BIT - 1));

   // ==================================================
   // frame sequencer
   // ==================================================

   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         shreg    <= '1;
         baud_cnt <= '0;
         bit_cnt  <= '0;
         o_busy   <= 1'b0;
      end else if (!o_busy) begin
         // a strobe is only taken when idle; while busy it is dropped.
         if (i_tx_stb) begin
            shreg    <= {1'b1, i_tx_data, 1'b0};
            baud_cnt <= '0;
            bit_cnt  <= '0;
            o_busy   <= 1'b1;
         end
      end else if (bit_end) begin
         baud_cnt <= '0;
         // ones shift in behind the frame so the line returns to idle.
         shreg    <= {1'b1, shreg[9:1]};
         if (bit_cnt == 4'd9) begin
            // the stop bit has just ended.
            o_busy <= 1'b0;
         end else begin
            bit_cnt <= bit_cnt + 4'd1;
         end
      end else begin
         baud_cnt <= baud_cnt + BAUD_W'(1);
      end
   end

   // the line follows the low bit, which rests at one between frames.
   assign o_tx = shreg[0];

endmodule

/* verilog/wb_regs.sv */
`timescale 1ns/1ps

module wb_regs (
   input  logic                         wb_clk,
   input  logic                         i_rst_n,
   input  logic [soc_pkg::WB_AW-1:0]    i_wb_adr,
   input  logic [soc_pkg::WB_DW-1:0]    i_wb_dat,
   input  logic [soc_pkg::WB_SW-1:0]    i_wb_sel,
   input  logic                         i_wb_we,
   input  logic                         i_wb_cyc,
   output logic [soc_pkg::WB_DW-1:0]    o_wb_rdt,
   output logic                         o_wb_ack,
   output logic [soc_pkg::GPIO_W-1:0]   o_test,
   output logic                         o_led,
   output logic                         o_tx_stb,
   output logic [7:0]                   o_tx_data,
   input  logic                         i_tx_busy,
   output logic [soc_pkg::RSTCNT_W-1:0] o_period,
   output logic                         o_period_wr
);

   import soc_pkg::*;

   logic [1:0]       reg_idx;
   logic             access;
   logic             wr;
   logic [WB_DW-1:0] rdata;

   // only address bits 3 to 2 are decoded, so the map repeats.
   assign reg_idx = i_wb_adr[3:2];

   // an access starts when cyc is seen and no ack is pending.
   // this keeps ack from rising two cycles in a row.
   assign access = i_wb_cyc && !o_wb_ack;
   assign wr     = access && i_wb_we;

   // ==================================================
   // acknowledge and control registers
   // ==================================================

   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_ack    <= 1'b0;
         o_test      <= '0;
         o_led       <= 1'b0;
         o_period    <= '0;
         o_tx_stb    <= 1'b0;
         o_period_wr <= 1'b0;
      end else begin
         o_wb_ack    <= access;
         // the strobes last a single cycle unless a write sets them again.
         o_tx_stb    <= 1'b0;
         o_period_wr <= 1'b0;

         if (wr) begin
            case (reg_idx)
               REG_GPIO: begin
                  if (i_wb_sel[0]) o_test <= i_wb_dat[GPIO_W-1:0];
               end
               REG_LED: begin
                  if (i_wb_sel[0]) o_led <= i_wb_dat[0];
               end
               REG_UART: begin
                  if (i_wb_sel[0]) o_tx_stb <= 1'b1;
               end
               REG_RSTP: begin
                  if (i_wb_sel[0]) o_period[7:0] <= i_wb_dat[7:0];
                  if (i_wb_sel[1]) o_period[RSTCNT_W-1:8] <= i_wb_dat[RSTCNT_W-1:8];
                  // the reset generator restarts its count on any interval write.
                  if (i_wb_sel[0] || i_wb_sel[1]) o_period_wr <= 1'b1;
               end
               default: begin
               end
            endcase
         end
      end
   end

   // ==================================================
   // payload registers
   // ==================================================

   // the transmit byte is taken together with the strobe.
   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_tx_data <= '0;
      end else if (wr && reg_idx == REG_UART && i_wb_sel[0]) begin
         o_tx_data <= i_wb_dat[7:0];
      end
   end

   // read data is captured on the access edge and held while ack is high.
   always_ff @(posedge wb_clk or negedge i_rst_n) begin
      if (!i_rst_n) begin
         o_wb_rdt <= '0;
      end else if (access) begin
         o_wb_rdt <= rdata;
      end
   end

   // read multiplexer; bits that a register lacks read as zero.
   always_comb begin
      rdata = '0;
      case (reg_idx)
         REG_GPIO: rdata[GPIO_W-1:0]   = o_test;
         REG_LED:  rdata[0]            = o_led;
         REG_UART: rdata[0]            = i_tx_busy;
         REG_RSTP: rdata[RSTCNT_W-1:0] = o_period;
         default:  rdata = '0;
      endcase
   end

endmodule

/* vlog.f */
verilog/soc_pkg.sv
verilog/reset_gen.sv
verilog/uart_tx.sv
verilog/wb_regs.sv
verilog/soc_top.sv
bench/soc_top_tb.sv
